/* build.f */
+incdir+bench
src/crc_pkg.sv
src/crc_comb.sv
src/crc_parallel.sv
src/crc_accumulator.sv
src/trailer_buffer.sv
src/frame_verdict.sv
src/crc_frame_checker.sv
bench/tb_crc_frame_checker.sv

/* bench/tb_frame_tasks.svh */
task automatic idle_cycle();
	@(negedge clk);
	data_valid  = 1'b0;
	frame_start = 1'b0;
	frame_end   = 1'b0;
endtask

task automatic send_byte(input crc_pkg::byte_t b, input logic first, input logic last);
	@(negedge clk);
	data        = b;
	data_valid  = 1'b1;
	frame_start = first;
	frame_end   = last;
endtask

task automatic set_config(input crc_pkg::size_code_t size, input crc_pkg::crc_t poly,
	input crc_pkg::crc_t init, input crc_pkg::crc_t xor_out);
	@(negedge clk);
	crc_size    = size;
	crc_poly    = poly;
	crc_init    = init;
	crc_xor_out = xor_out;
endtask

function automatic byte_q_t random_payload(input int len);
	byte_q_t q;
	for (int i = 0; i < len; i++)
		q.push_back(crc_pkg::byte_t'($random(seed)));
	return q;
endfunction

// Body plus optional check value, verdict queued on the frame_end beat
task automatic send_beats(input byte_q_t body, input logic with_check, input crc_pkg::crc_t check,
	input crc_pkg::crc_t calc, input logic ok, input int gap_every);
	byte_q_t beats;
	beats = body;
	if (with_check)
		for (int k = int'(crc_size); k >= 0; k--)
			beats.push_back(crc_pkg::byte_t'(check >> (8 * k)));  // MSB first
	for (int i = 0; i < beats.size(); i++)
	begin
		if (gap_every > 0 && i > 0 && i % gap_every == 0)
			idle_cycle();
		send_byte(beats[i], i == 0, i == beats.size() - 1);
	end
	exp_ok_q.push_back(ok && with_check);
	exp_short_q.push_back(!with_check);
	exp_calc_q.push_back(calc);
	exp_rx_q.push_back(check);
endtask

// Trailer from the clean payload, flip_bit below zero leaves the payload intact
task automatic send_frame(input byte_q_t payload, input int gap_every, input int flip_bit);
	byte_q_t sent;
	sent = payload;
	if (flip_bit >= 0)
		sent[flip_bit / 8] = sent[flip_bit / 8] ^ crc_pkg::byte_t'(1 << (flip_bit % 8));
	send_beats(sent, 1'b1, model_crc(payload), model_crc(sent), flip_bit < 0, gap_every);
endtask

task automatic send_corrupt_frame(input byte_q_t payload, input int bad_byte);
	crc_pkg::crc_t good;
	good = model_crc(payload);
	send_beats(payload, 1'b1, good ^ (crc_pkg::crc_t'(8'h5a) << (8 * bad_byte)), good, 1'b0, 0);
endtask

task automatic send_short_frame(input int len);
	send_beats(random_payload(len), 1'b0, '0, '0, 1'b0, 0);
endtask

// Wait until every queued verdict has come out
task automatic finish_frames();
	idle_cycle();
	while (exp_ok_q.size() > 0)
		@(posedge clk);
endtask

/* bench/tb_crc_frame_checker.sv */
`timescale 1ns/1ps

module tb_crc_frame_checker;

	typedef crc_pkg::byte_t byte_q_t [$];

	localparam int CYCLE_LIMIT = 3000;  // Scenarios run for well under half of this

	logic                clk;
	logic                rst;
	crc_pkg::byte_t      data;
	logic                data_valid;
	logic                frame_start;
	logic                frame_end;
	crc_pkg::crc_t       crc_poly;
	crc_pkg::crc_t       crc_init;
	crc_pkg::crc_t       crc_xor_out;
	crc_pkg::size_code_t crc_size;
	logic                result_valid;
	logic                crc_ok;
	logic                short_frame;
	crc_pkg::crc_t       crc_received;
	crc_pkg::crc_t       crc_computed;

	integer        seed;
	int            cycles = 0;
	string         test_name = "reset";
	byte_q_t       check_q;
	crc_pkg::crc_t known;

	// Verdicts queued at frame_end, head copied out each falling edge
	logic          exp_ok_q [$];
	logic          exp_short_q [$];
	crc_pkg::crc_t exp_calc_q [$];
	crc_pkg::crc_t exp_rx_q [$];
	logic          exp_pending = 1'b0;
	logic          exp_ok;
	logic          exp_short;
	crc_pkg::crc_t exp_calc;
	crc_pkg::crc_t exp_rx;

	crc_pkg::crc_t poly_tab [4] = '{32'h07, 32'h1021, 32'h0086_4cfb, 32'h04c1_1db7};  // By size
	crc_pkg::crc_t init_tab [8] = '{0, 0, 0, 0, 32'h00, 32'hffff, 32'h00b7_04ce, 32'hffff_ffff};
	crc_pkg::crc_t xor_tab  [8] = '{0, 0, 0, 0, 32'h55, 32'h0, 32'h0, 32'hffff_ffff};

	crc_frame_checker UUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic stop_on_mismatch(input string what, input crc_pkg::crc_t expected,
		input crc_pkg::crc_t actual);
		$display("=== FAIL ===");
		$display("** Error [%s] %s expected %h actual %h", test_name, what, expected, actual);
		$fatal(1, "Simulation stopped on a wrong value");
	endtask

	task automatic stop_on_fault(input string what);
		$display("=== FAIL ===");
		$display("Error in %s: %s", test_name, what);
		$fatal(1, "Simulation stopped");
	endtask

	// Bit-serial MSB-first reference with a right-justified register
	function automatic crc_pkg::crc_t model_crc(input byte_q_t bytes);
		int            width;
		crc_pkg::crc_t mask;
		crc_pkg::crc_t acc;
		logic          fb;
		width = 8 * (int'(crc_size) + 1);
		mask  = crc_pkg::crc_t'((64'd1 << width) - 1);
		acc   = crc_init & mask;
		foreach (bytes[i])
			for (int b = 7; b >= 0; b--)
			begin
				fb  = acc[width-1] ^ bytes[i][b];
				acc = (acc << 1) & mask;
				if (fb)
					acc = acc ^ (crc_poly & mask);
			end
		return (acc ^ crc_xor_out) & mask;
	endfunction

`include "tb_frame_tasks.svh"

	always @(negedge clk)
	begin
		exp_pending = exp_ok_q.size() > 0;
		if (exp_pending)
		begin
			exp_ok    = exp_ok_q[0];
			exp_short = exp_short_q[0];
			exp_calc  = exp_calc_q[0];
			exp_rx    = exp_rx_q[0];
		end
	end

	always @(posedge clk)
	begin
		if (!rst && result_valid && exp_ok_q.size() > 0)
		begin
			void'(exp_ok_q.pop_front());
			void'(exp_short_q.pop_front());
			void'(exp_calc_q.pop_front());
			void'(exp_rx_q.pop_front());
		end
	end

	// Set by the second edge after frame_end, so seen at the third sample
	a_latency : assert property (@(posedge clk) disable iff (rst)
		data_valid && frame_end |-> ##3 result_valid)
		else stop_on_fault("no result_valid pulse two cycles after frame_end");

	a_no_stray : assert property (@(posedge clk) disable iff (rst)
		result_valid |-> $past(data_valid && frame_end, 3) && exp_pending)
		else stop_on_fault("result_valid without a matching frame_end");

	a_crc_ok : assert property (@(posedge clk) disable iff (rst)
		result_valid |-> crc_ok == exp_ok)
		else stop_on_mismatch("crc_ok", crc_pkg::crc_t'(exp_ok), crc_pkg::crc_t'($sampled(crc_ok)));

	a_short : assert property (@(posedge clk) disable iff (rst)
		result_valid |-> short_frame == exp_short)
		else stop_on_mismatch("short_frame", crc_pkg::crc_t'(exp_short),
			crc_pkg::crc_t'($sampled(short_frame)));

	a_computed : assert property (@(posedge clk) disable iff (rst)
		result_valid && !exp_short |-> crc_computed == exp_calc)
		else stop_on_mismatch("crc_computed", exp_calc, $sampled(crc_computed));

	a_received : assert property (@(posedge clk) disable iff (rst)
		result_valid && !exp_short |-> crc_received == exp_rx)
		else stop_on_mismatch("crc_received", exp_rx, $sampled(crc_received));

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
			stop_on_fault("timeout, the run went past the cycle limit");
	end

	initial
	begin
		seed        = 32'hd915;
		rst         = 1'b1;
		data        = '0;
		data_valid  = 1'b0;
		frame_start = 1'b0;
		frame_end   = 1'b0;
		crc_size    = crc_pkg::SIZE_8;
		crc_poly    = '0;
		crc_init    = '0;
		crc_xor_out = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		test_name = "idle_after_reset";
		repeat (10) idle_cycle();

		// Known check value of CRC-32/BZIP2 over the ASCII digits 1 to 9
		test_name = "model_check";
		set_config(crc_pkg::SIZE_32, 32'h04c1_1db7, 32'hffff_ffff, 32'hffff_ffff);
		check_q = '{8'h31, 8'h32, 8'h33, 8'h34, 8'h35, 8'h36, 8'h37, 8'h38, 8'h39};
		known   = model_crc(check_q);
		a_model_known : assert (known == 32'hfc89_1918)
			else stop_on_mismatch("model check value", 32'hfc89_1918, known);

		// Plain configs first, then nonzero init or final XOR
		for (int c = 0; c < 8; c++)
		begin
			test_name = $sformatf("width_%0d_cfg_%0d", 8 * (c % 4 + 1), c);
			set_config(crc_pkg::size_code_t'(c % 4), poly_tab[c % 4], init_tab[c], xor_tab[c]);
			send_frame(random_payload(6 + c), 0, -1);
			send_frame(random_payload(11), 3, -1);  // Back to back with gaps
			finish_frames();
		end

		test_name = "crc16_errors";
		set_config(crc_pkg::SIZE_16, 32'h1021, 32'hffff, 32'h0);
		send_frame(random_payload(9), 0, 13);
		send_frame(random_payload(9), 2, 70);
		send_corrupt_frame(random_payload(7), 0);
		send_corrupt_frame(random_payload(7), 1);
		finish_frames();

		test_name = "crc32_errors";
		set_config(crc_pkg::SIZE_32, 32'h04c1_1db7, 32'hffff_ffff, 32'hffff_ffff);
		send_corrupt_frame(random_payload(10), 3);
		send_frame(random_payload(10), 0, 0);
		finish_frames();

		test_name = "short_frames";
		send_short_frame(1);
		send_short_frame(3);
		send_short_frame(4);
		finish_frames();
		set_config(crc_pkg::SIZE_8, 32'h07, 32'h0, 32'h55);
		send_short_frame(1);
		send_frame(random_payload(1), 0, -1);
		finish_frames();

		test_name = "mixed_stream";
		set_config(crc_pkg::SIZE_16, 32'h1021, 32'h0, 32'h0);
		send_frame(random_payload(5), 2, -1);
		send_corrupt_frame(random_payload(6), 1);
		send_frame(random_payload(4), 1, -1);
		send_short_frame(2);
		send_frame(random_payload(12), 0, -1);
		finish_frames();
		repeat (5) idle_cycle();

		$display("=== PASS ===");
		$finish;
	end

endmodule

/* src/crc_frame_checker.sv */
`timescale 1ns/1ps

module crc_frame_checker (
	input  logic                clk,
	input  logic                rst,
	input  crc_pkg::byte_t      data,
	input  logic                data_valid,
	input  logic                frame_start,
	input  logic                frame_end,
	input  crc_pkg::crc_t       crc_poly,
	input  crc_pkg::crc_t       crc_init,
	input  crc_pkg::crc_t       crc_xor_out,
	input  crc_pkg::size_code_t crc_size,
	output logic                result_valid,
	output logic                crc_ok,
	output logic                short_frame,
	output crc_pkg::crc_t       crc_received,
	output crc_pkg::crc_t       crc_computed
);

	crc_pkg::byte_t payload_byte;
	logic           payload_valid;
	crc_pkg::crc_t  trailer_value;
	crc_pkg::crc_t  crc_running;

	// Holds back the check value bytes
	trailer_buffer u_trailer (
		.clk           (clk),
		.rst           (rst),
		.data          (data),
		.data_valid    (data_valid),
		.frame_start   (frame_start),
		.crc_size      (crc_size),
		.payload_byte  (payload_byte),
		.payload_valid (payload_valid),
		.trailer_value (trailer_value)
	);

	crc_accumulator u_accum (
		.clk           (clk),
		.rst           (rst),
		.frame_start   (frame_start),
		.payload_byte  (payload_byte),
		.payload_valid (payload_valid),
		.crc_poly      (crc_poly),
		.crc_init      (crc_init),
		.crc_size      (crc_size),
		.crc_running   (crc_running)
	);

	frame_verdict u_verdict (
		.clk           (clk),
		.rst           (rst),
		.data_valid    (data_valid),
		.frame_start   (frame_start),
		.frame_end     (frame_end),
		.crc_running   (crc_running),
		.trailer_value (trailer_value),
		.crc_xor_out   (crc_xor_out),
		.crc_size      (crc_size),
		.result_valid  (result_valid),
		.crc_ok        (crc_ok),
		.short_frame   (short_frame),
		.crc_received  (crc_received),
		.crc_computed  (crc_computed)
	);

endmodule

/* src/frame_verdict.sv */
`timescale 1ns/1ps

module frame_verdict (
	input  logic                clk,
	input  logic                rst,
	input  logic                data_valid,
	input  logic                frame_start,
	input  logic                frame_end,
	input  crc_pkg::crc_t       crc_running,
	input  crc_pkg::crc_t       trailer_value,
	input  crc_pkg::crc_t       crc_xor_out,
	input  crc_pkg::size_code_t crc_size,
	output logic                result_valid,
	output logic                crc_ok,
	output logic                short_frame,
	output crc_pkg::crc_t       crc_received,
	output crc_pkg::crc_t       crc_computed
);

	crc_pkg::len_t byte_cnt;
	crc_pkg::len_t trailer_len;
	crc_pkg::crc_t width_mask;
	crc_pkg::crc_t rx_q;       // Received check value, masked
	crc_pkg::crc_t calc_q;     // Computed check value after final XOR
	logic          short_q;
	logic          end_seen;   // Frame closed at the last edge
	logic          cap_valid;  // Capture stage holds a frame

	assign trailer_len = crc_pkg::len_t'(crc_size) + 1'b1;
	assign width_mask  = crc_pkg::size_mask(crc_size);

	always_ff @(posedge clk)
	begin
		if (rst)
			byte_cnt <= '0;
		else if (data_valid)
		begin
			if (frame_start)
				byte_cnt <= crc_pkg::len_t'(1);
			else if (byte_cnt != '1)
				byte_cnt <= byte_cnt + 1'b1;  // Saturate so long frames never look short
		end
	end

	// Three-stage pipe: end seen, capture, result
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			end_seen     <= 1'b0;
			cap_valid    <= 1'b0;
			result_valid <= 1'b0;
			crc_ok       <= 1'b0;
			short_frame  <= 1'b0;
		end
		else
		begin
			end_seen     <= data_valid && frame_end;
			cap_valid    <= end_seen;
			result_valid <= cap_valid;
			if (cap_valid)
			begin
				crc_ok      <= (rx_q == calc_q) && !short_q;
				short_frame <= short_q;
			end
		end
	end

	// Registers are final one edge after frame_end, so capture here
	always_ff @(posedge clk)
	begin
		if (end_seen)
		begin
			rx_q    <= trailer_value & width_mask;
			calc_q  <= (crc_running ^ crc_xor_out) & width_mask;
			short_q <= (byte_cnt <= trailer_len);  // No payload left once trailer is removed
		end
		if (cap_valid)
		begin
			crc_received <= rx_q;
			crc_computed <= calc_q;
		end
	end

	a_single_pulse : assert property (@(posedge clk) disable iff (rst)
		result_valid |=> !result_valid)
		else $error("result_valid held for more than one cycle");

endmodule

/* src/trailer_buffer.sv */
`timescale 1ns/1ps

module trailer_buffer (
	input  logic                clk,
	input  logic                rst,
	input  crc_pkg::byte_t      data,
	input  logic                data_valid,
	input  logic                frame_start,
	input  crc_pkg::size_code_t crc_size,
	output crc_pkg::byte_t      payload_byte,
	output logic                payload_valid,
	output crc_pkg::crc_t       trailer_value
);

	crc_pkg::byte_t sr [crc_pkg::TRAILER_MAX];  // Index 0 holds the newest byte
	crc_pkg::fill_t fill;
	crc_pkg::fill_t trailer_len;
	logic           full;

	assign trailer_len = crc_pkg::fill_t'(crc_size) + 1'b1;
	assign full        = (fill == trailer_len);

	// A new byte into a full buffer pushes the oldest trailer byte out as payload
	assign payload_valid = data_valid && !frame_start && full;
	assign payload_byte  = sr[crc_size];

	always_ff @(posedge clk)
	begin
		if (rst)
			fill <= '0;
		else if (data_valid)
		begin
			if (frame_start)
				fill <= crc_pkg::fill_t'(1);  // Old frame's leftovers are discarded
			else if (!full)
				fill <= fill + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (data_valid)
		begin
			sr[0] <= data;
			for (int i = 1; i < crc_pkg::TRAILER_MAX; i++)
				sr[i] <= sr[i-1];
		end
	end

	// Earliest received byte ends up most significant
	always_comb
	begin
		for (int i = 0; i < crc_pkg::TRAILER_MAX; i++)
			trailer_value[i*crc_pkg::BYTE_W +: crc_pkg::BYTE_W] = sr[i];
	end

	// Mid-frame byte finds an open buffer no deeper than the trailer
	a_fill_in_range : assert property (@(posedge clk) disable iff (rst)
		data_valid && !frame_start |-> fill != '0 && fill <= trailer_len)
		else $error("byte outside an open frame or trailer length changed in a frame");

endmodule

/* src/crc_accumulator.sv */
`timescale 1ns/1ps

module crc_accumulator (
	input  logic                clk,
	input  logic                rst,
	input  logic                frame_start,
	input  crc_pkg::byte_t      payload_byte,
	input  logic                payload_valid,
	input  crc_pkg::crc_t       crc_poly,
	input  crc_pkg::crc_t       crc_init,
	input  crc_pkg::size_code_t crc_size,
	output crc_pkg::crc_t       crc_running
);

	crc_pkg::crc_t       width_mask;
	crc_pkg::crc_t       crc_seed;
	crc_pkg::crc_t       crc_next;
	crc_pkg::crc_t       crc_q;
	crc_pkg::size_code_t frame_size;   // Width in force for the open frame
	logic                seed_pending; // No payload byte seen yet in this frame

	assign width_mask = crc_pkg::size_mask(crc_size);

	// First payload byte starts from the programmed init value
	assign crc_seed = seed_pending ? crc_init : crc_q;

	crc_parallel
	#(
		.CRC_SIZE      (crc_pkg::CRC_MAX),
		.FRAME_SIZE    (crc_pkg::BYTE_W)
	) u_step
	(
		.data_in       (payload_byte),
		.crc_init      (crc_seed),
		.crc_poly      (crc_poly),
		.crc_poly_size (width_mask),
		.crc_out       (crc_next)
	);

	always_ff @(posedge clk)
	begin
		if (rst)
			seed_pending <= 1'b1;
		else if (frame_start)
			seed_pending <= 1'b1;
		else if (payload_valid)
			seed_pending <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (payload_valid)
		begin
			crc_q <= crc_next;
			if (seed_pending)
				frame_size <= crc_size;
		end
	end

	assign crc_running = crc_q;

	// Width must stay put from the first payload byte to the last
	a_size_stable : assert property (@(posedge clk) disable iff (rst)
		payload_valid && !seed_pending |-> crc_size == frame_size)
		else $error("crc_size changed inside a frame");

endmodule

/* src/crc_parallel.sv */
`timescale 1ns/1ps

module crc_parallel
#(
	parameter int CRC_SIZE   = crc_pkg::CRC_MAX,  // Width of the CRC datapath
	parameter int FRAME_SIZE = crc_pkg::BYTE_W    // Data bits consumed per step
)(
	input  crc_pkg::byte_t data_in,
	input  crc_pkg::crc_t  crc_init,       // Right-justified start value
	input  crc_pkg::crc_t  crc_poly,       // Right-justified polynomial
	input  crc_pkg::crc_t  crc_poly_size,  // Thermometer, low width bits set
	output crc_pkg::crc_t  crc_out         // Right-justified result
);

	logic [CRC_SIZE-1:0] chain [0:FRAME_SIZE];
	logic [CRC_SIZE-1:0] init_top;
	logic [CRC_SIZE-1:0] poly_top;
	logic [CRC_SIZE-1:0] size_rev;

	// Move init and poly up so their MSB sits at the register top
	for (genvar m = 0; m < CRC_SIZE; m++)
	begin : g_justify
		logic [CRC_SIZE-1:0] pick;

		// One-hot on the source bit that lands in position m
		assign pick = (crc_poly_size >> (CRC_SIZE - m - 1)) &
			~(crc_poly_size >> (CRC_SIZE - m));

		assign init_top[m] = |(crc_init & pick);
		assign poly_top[m] = |(crc_poly & pick);
	end

	assign chain[0] = init_top;

	for (genvar i = 0; i < FRAME_SIZE; i++)
	begin : g_step
		crc_comb
		#(
			.CRC_SIZE      (CRC_SIZE),
			.MASK          ({CRC_SIZE{1'b1}})
		) u_comb
		(
			.data_in       (data_in[FRAME_SIZE-1-i]),  // MSB first
			.crc_in        (chain[i]),
			.crc_poly      (poly_top),
			.crc_poly_size (crc_poly_size[CRC_SIZE-2:0]),
			.crc_out       (chain[i+1])
		);
	end

	// Bring the top-justified result back down to bit 0
	for (genvar l = 0; l < CRC_SIZE; l++)
	begin : g_out
		logic [CRC_SIZE-1:0] take;

		assign size_rev[l] = crc_poly_size[CRC_SIZE-1-l];
		assign take = (size_rev << l) & ~(size_rev << (l + 1));
		assign crc_out[l] = |(chain[FRAME_SIZE] & take);
	end

endmodule

/* src/crc_comb.sv */
`timescale 1ns/1ps

module crc_comb
#(
	parameter int                  CRC_SIZE = crc_pkg::CRC_MAX,  // Register width
	parameter logic [CRC_SIZE-1:0] MASK     = '1                 // Bits the size mask may clear
)(
	input  logic                data_in,        // One data bit, MSB-first order
	input  crc_pkg::crc_t       crc_in,         // Top-justified CRC from the previous step
	input  crc_pkg::crc_t       crc_poly,       // Top-justified polynomial taps
	input  logic [CRC_SIZE-2:0] crc_poly_size,  // Thermometer of the selected width
	output crc_pkg::crc_t       crc_out
);

	logic [CRC_SIZE-2:0] size_rev;
	logic [CRC_SIZE-2:0] mask_rev;
	logic [CRC_SIZE-2:0] keep;
	logic [CRC_SIZE-1:0] feedback;

	for (genvar i = 0; i < CRC_SIZE - 1; i++)
	begin : g_rev
		assign size_rev[i] = crc_poly_size[CRC_SIZE-2-i];
		assign mask_rev[i] = MASK[CRC_SIZE-2-i];
	end

	// Shifted bits that land below the active CRC field are dropped
	assign keep = size_rev | ~mask_rev;

	assign feedback = crc_poly & {CRC_SIZE{crc_in[CRC_SIZE-1] ^ data_in}};

	assign crc_out = {(crc_in[CRC_SIZE-2:0] & keep) ^ feedback[CRC_SIZE-1:1], feedback[0]};

endmodule

/* src/crc_pkg.sv */
package crc_pkg;

	localparam int CRC_MAX     = 32;                 // Widest CRC the datapath handles
	localparam int BYTE_W      = 8;                  // One stream beat
	localparam int TRAILER_MAX = CRC_MAX / BYTE_W;   // Check value bytes at full width
	localparam int LEN_W       = 16;
	localparam int FILL_W      = $clog2(TRAILER_MAX + 1);

	typedef logic [CRC_MAX-1:0] crc_t;    // Right-justified CRC, poly, init or XOR value
	typedef logic [BYTE_W-1:0]  byte_t;
	typedef logic [1:0]         size_code_t;
	typedef logic [LEN_W-1:0]   len_t;    // Frame byte count
	typedef logic [FILL_W-1:0]  fill_t;   // Trailer buffer occupancy

	// Width select, trailer length is code plus one
	localparam size_code_t SIZE_8  = 2'd0;
	localparam size_code_t SIZE_16 = 2'd1;
	localparam size_code_t SIZE_24 = 2'd2;
	localparam size_code_t SIZE_32 = 2'd3;

	// Thermometer mask with the low CRC-width bits set
	function automatic crc_t size_mask(input size_code_t size);
		crc_t mask;
		unique case (size)
			SIZE_8:
				mask = 32'h0000_00ff;
			SIZE_16:
				mask = 32'h0000_ffff;
			SIZE_24:
				mask = 32'h00ff_ffff;
			SIZE_32:
				mask = 32'hffff_ffff;
		endcase
		return mask;
	endfunction

endpackage
